//--- source/spi_pkg.sv
package spi_pkg;

  // Bits clocked out on mosi for every command, MSB first
  localparam int SPI_CMD_WIDTH = 12;

  // Bit 11 of the command word selects the operation
  typedef enum logic
  {
    SPI_OP_READ  = 1'b0,
    SPI_OP_WRITE = 1'b1
  } spi_op_e;

  // Laid out exactly as the command word on the bus
  typedef struct packed
  {
    spi_op_e     op;       // Bit 11
    logic [10:0] payload;  // Address for a read, data for a write
  } spi_cmd_t;

  // Job handed from decode to the engine
  typedef struct packed
  {
    spi_cmd_t cmd;    // Held stable for the whole transfer
    logic     start;  // One cycle strobe that launches a frame
  } spi_job_t;

  // One miso sample from the engine to capture
  typedef struct packed
  {
    logic strobe;   // A miso bit was sampled this cycle
    logic bit_val;
    logic last;     // Final bit of the read word
  } spi_sample_t;

endpackage

//--- source/spi_cmd_decode.sv
`timescale 1ns/1ps

module spi_cmd_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::spi_cmd_t cmd_in,
  input  logic              cmd_vld,
  input  logic              done,
  output logic              cmd_rdy,
  output spi_pkg::spi_job_t job
);
  import spi_pkg::*;

  logic     busy_q;
  logic     start_q;
  logic     accept;
  spi_cmd_t cmd_q;

  // A command only counts while idle, anything offered while busy is dropped
  assign accept  = cmd_vld && !busy_q;
  assign cmd_rdy = !busy_q;

  // Busy from the cycle after acceptance until the cycle after done
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end
    else
    begin
      start_q <= accept;  // Start lines up with cmd_rdy falling
      if (accept)
      begin
        busy_q <= 1'b1;
      end
      else if (done)
      begin
        busy_q <= 1'b0;
      end
    end
  end

  // The engine reads the op bit at the end of the command phase,
  // so the word must stay put until the frame is over
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_in;
    end
  end

  assign job.cmd   = cmd_q;
  assign job.start = start_q;

endmodule

//--- source/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine #(
  parameter int READ_WIDTH = 8,
  parameter int SCLK_HALF  = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  spi_pkg::spi_job_t    job,
  input  logic                 miso,
  output logic                 sclk,
  output logic                 cs,
  output logic                 mosi,
  output spi_pkg::spi_sample_t sample,
  output logic                 done
);
  import spi_pkg::*;

  localparam int CNT_W = $clog2(SPI_CMD_WIDTH + READ_WIDTH);
  localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_SHIFT,
    ST_READ,
    ST_FINISH
  } state_e;

  state_e                   state_q;
  logic [DIV_W-1:0]         div_q;
  logic [CNT_W-1:0]         bit_q;
  logic [SPI_CMD_WIDTH-1:0] sh_q;
  logic                     sclk_q;
  logic                     cs_q;
  logic                     done_q;
  spi_sample_t              sample_q;

  logic active;
  logic half_end;
  logic rise;
  logic fall;
  logic cmd_last;
  logic read_last;

  assign active    = (state_q == ST_SHIFT) || (state_q == ST_READ);
  assign half_end  = div_q == DIV_W'(SCLK_HALF - 1);
  assign rise      = active && half_end && !sclk_q;
  assign fall      = active && half_end && sclk_q;
  assign cmd_last  = bit_q == CNT_W'(SPI_CMD_WIDTH - 1);
  assign read_last = bit_q == CNT_W'(READ_WIDTH - 1);

  // Half period divider, runs only while cs is low
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_q <= '0;
    end
    else if (active && !half_end)
    begin
      div_q <= div_q + 1'b1;
    end
    else
    begin
      div_q <= '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= ST_IDLE;
      bit_q    <= '0;
      sh_q     <= '0;   // Keeps mosi low out of reset
      sclk_q   <= 1'b0;
      cs_q     <= 1'b1;
      done_q   <= 1'b0;
      sample_q <= '0;
    end
    else
    begin
      done_q   <= 1'b0;
      sample_q <= '0;
      case (state_q)
        ST_IDLE:
        begin
          if (job.start)
          begin
            state_q <= ST_SHIFT;
            cs_q    <= 1'b0;
            sh_q    <= job.cmd;  // MSB is on mosi as cs falls
            bit_q   <= '0;
          end
        end
        ST_SHIFT:
        begin
          if (rise)
          begin
            sclk_q <= 1'b1;
          end
          if (fall)
          begin
            sclk_q <= 1'b0;
            sh_q   <= {sh_q[SPI_CMD_WIDTH-2:0], 1'b0};  // Zeros fill in, so mosi ends low
            if (cmd_last)
            begin
              bit_q <= '0;
              if (job.cmd.op == SPI_OP_WRITE)
              begin
                state_q <= ST_FINISH;
                cs_q    <= 1'b1;
                done_q  <= 1'b1;
              end
              else
              begin
                state_q <= ST_READ;
              end
            end
            else
            begin
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        ST_READ:
        begin
          // Mode 0 so the slave drives on the falling edge and we take it on the rising one
          if (rise)
          begin
            sclk_q           <= 1'b1;
            sample_q.strobe  <= 1'b1;
            sample_q.bit_val <= miso;
            sample_q.last    <= read_last;
          end
          if (fall)
          begin
            sclk_q <= 1'b0;
            if (read_last)
            begin
              state_q <= ST_FINISH;
              cs_q    <= 1'b1;
              done_q  <= 1'b1;
            end
            else
            begin
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        ST_FINISH:
        begin
          state_q <= ST_IDLE;  // Decode drops busy on this same edge
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign sclk   = sclk_q;
  assign cs     = cs_q;
  assign mosi   = sh_q[SPI_CMD_WIDTH-1];
  assign sample = sample_q;
  assign done   = done_q;

endmodule

//--- source/spi_read_capture.sv
`timescale 1ns/1ps

module spi_read_capture #(
  parameter int READ_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_pkg::spi_sample_t  sample,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  logic [READ_WIDTH-1:0] cap_q;
  logic [READ_WIDTH-1:0] cap_next;

  // First sampled bit ends up as the MSB
  assign cap_next = (cap_q << 1) | READ_WIDTH'(sample.bit_val);

  always_ff @(posedge clk)
  begin
    if (sample.strobe)
    begin
      cap_q <= cap_next;
    end
  end

  // The word is published on the last strobe and held until the next read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= sample.strobe && sample.last;
      if (sample.strobe && sample.last)
      begin
        read_data <= cap_next;
      end
    end
  end

endmodule

//--- source/spi_ctrl_top.sv
`timescale 1ns/1ps

module spi_ctrl_top #(
  parameter int READ_WIDTH = 8,  // 1 to 16
  parameter int SCLK_HALF  = 2   // clk cycles per sclk half period
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_pkg::spi_cmd_t     cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);
  import spi_pkg::*;

  spi_job_t    job;
  spi_sample_t sample;
  logic        done;

  // Only decode looks at cmd_vld
  spi_cmd_decode spi_cmd_decode_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .done    (done),
    .cmd_rdy (cmd_rdy),
    .job     (job)
  );

  spi_shift_engine #(
    .READ_WIDTH (READ_WIDTH),
    .SCLK_HALF  (SCLK_HALF)
  ) spi_shift_engine_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .job    (job),
    .miso   (miso),
    .sclk   (sclk),
    .cs     (cs),
    .mosi   (mosi),
    .sample (sample),
    .done   (done)
  );

  spi_read_capture #(
    .READ_WIDTH (READ_WIDTH)
  ) spi_read_capture_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .sample    (sample),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

//--- verif/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model #(
  parameter int READ_WIDTH = 8
) (
  input  logic                  sclk,
  input  logic                  cs,
  input  logic                  mosi,
  input  logic [READ_WIDTH-1:0] resp,        // Answer for the command in rx_cmd
  output logic                  miso,
  output spi_pkg::spi_cmd_t     rx_cmd,
  output spi_pkg::spi_cmd_t     frame_cmd,
  output int                    frame_bits,
  output int                    frame_cnt
);
  import spi_pkg::*;

  logic [SPI_CMD_WIDTH-1:0] rx_q = '0;
  logic [SPI_CMD_WIDTH-1:0] frame_q = '0;
  logic                     miso_q = 1'b0;
  int                       bit_cnt = 0;
  int                       bits_q = 0;
  int                       frames_q = 0;

  // Mode 0 so mosi is taken on the rising edge, a frame is reported when cs rises
  always @(posedge sclk or posedge cs)
  begin
    if (cs)
    begin
      if (bit_cnt != 0)
      begin
        frame_q  <= rx_q;
        bits_q   <= bit_cnt;
        frames_q <= frames_q + 1;
      end
      bit_cnt <= 0;
    end
    else
    begin
      if (bit_cnt < SPI_CMD_WIDTH)
        rx_q <= {rx_q[SPI_CMD_WIDTH-2:0], mosi};
      bit_cnt <= bit_cnt + 1;
    end
  end

  // The first read bit goes out on the falling edge that ends the command
  always @(negedge sclk or posedge cs)
  begin
    if (cs)
      miso_q <= 1'b0;
    else if (rx_cmd.op == SPI_OP_READ && bit_cnt >= SPI_CMD_WIDTH &&
             bit_cnt < SPI_CMD_WIDTH + READ_WIDTH)
      miso_q <= resp[READ_WIDTH - 1 - (bit_cnt - SPI_CMD_WIDTH)];
    else
      miso_q <= 1'b0;
  end

  assign rx_cmd     = spi_cmd_t'(rx_q);
  assign frame_cmd  = spi_cmd_t'(frame_q);
  assign frame_bits = bits_q;
  assign frame_cnt  = frames_q;
  assign miso       = miso_q;

endmodule

//--- verif/spi_ctrl_tb.sv
`timescale 1ns/1ps

module spi_ctrl_tb;
  import spi_pkg::*;

  localparam int READ_WIDTH = 8;
  localparam int SCLK_HALF  = 2;
  localparam int TIMEOUT    = 2000;  // clk cycles allowed for any single wait

  logic clk;
  logic rst_n;
  spi_cmd_t cmd_in;
  logic cmd_vld;
  logic cmd_rdy;
  logic sclk;
  logic cs;
  logic mosi;
  logic miso;
  logic read_vld;
  logic [READ_WIDTH-1:0] read_data;

  spi_cmd_t slave_rx_cmd;
  spi_cmd_t slave_frame_cmd;
  logic [READ_WIDTH-1:0] slave_resp;
  int slave_frame_bits;
  int slave_frames;

  spi_cmd_t exp_cmd_q[$];
  logic [READ_WIDTH-1:0] exp_read_q[$];
  spi_cmd_t exp_c;
  int frames_seen = 0;
  int read_pulses = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int errors_at_start = 0;
  logic [15:0] lfsr = 16'd47832;

  spi_ctrl_top #(
    .READ_WIDTH (READ_WIDTH),
    .SCLK_HALF  (SCLK_HALF)
  ) spi_ctrl_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model #(
    .READ_WIDTH (READ_WIDTH)
  ) spi_slave_model_i (
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .resp       (slave_resp),
    .miso       (miso),
    .rx_cmd     (slave_rx_cmd),
    .frame_cmd  (slave_frame_cmd),
    .frame_bits (slave_frame_bits),
    .frame_cnt  (slave_frames)
  );

  // Low bits of the payload scrambled with a fixed pattern
  function automatic logic [READ_WIDTH-1:0] spi_ref_read(input spi_cmd_t c);
    return READ_WIDTH'(c.payload) ^ READ_WIDTH'(8'h5A);
  endfunction

  assign slave_resp = spi_ref_read(slave_rx_cmd);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_cmd(output spi_cmd_t c);
    logic [SPI_CMD_WIDTH-1:0] w;
    for (int i = 0; i < SPI_CMD_WIDTH; i++)
    begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
    c = spi_cmd_t'(w);
  endtask

  task automatic check_cmd(input string name, input spi_cmd_t exp, input spi_cmd_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %03h, actual %03h", name, exp, act);
    end
  endtask

  task automatic check_read(input string name, input logic [READ_WIDTH-1:0] exp,
                            input logic [READ_WIDTH-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Test failed");
    $finish;
  endtask

  task automatic wait_rdy(input string what);
    int waited;
    waited = 0;
    while (!cmd_rdy)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run($sformatf("cmd_rdy never rose during %s", what));
    end
  endtask

  task automatic wait_idle(input string what);
    int waited;
    waited = 0;
    while (!(cmd_rdy && cs && exp_cmd_q.size() == 0 && exp_read_q.size() == 0))
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_run($sformatf("%s did not finish, %0d frames and %0d reads still missing",
                            what, exp_cmd_q.size(), exp_read_q.size()));
    end
  endtask

  // Offer a command on a falling edge and hold it until the DUT takes it
  task automatic send_cmd(input spi_cmd_t c);
    @(negedge clk);
    cmd_in  = c;
    cmd_vld = 1'b1;
    wait_rdy($sformatf("command %03h", c));
    exp_cmd_q.push_back(c);
    if (c.op == SPI_OP_READ)
      exp_read_q.push_back(spi_ref_read(c));
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_at_start)
      $display("%-12s ok", name);
    else
      $display("%-12s %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  // Compares every read word and every slave frame against what was sent
  always @(posedge clk)
  begin
    if (rst_n && read_vld)
    begin
      read_pulses++;
      if (exp_read_q.size() == 0)
      begin
        errors++;
        $display("read_vld pulsed while no read was outstanding");
      end
      else
        check_read($sformatf("read %0d", read_pulses), exp_read_q.pop_front(), read_data);
    end
    if (slave_frames != frames_seen)
    begin
      frames_seen++;
      if (exp_cmd_q.size() == 0)
      begin
        errors++;
        $display("Slave saw frame %0d while no command was outstanding", frames_seen);
      end
      else
      begin
        exp_c = exp_cmd_q.pop_front();
        check_cmd($sformatf("frame %0d", frames_seen), exp_c, slave_frame_cmd);
        check_count($sformatf("frame %0d bits", frames_seen),
                    (exp_c.op == SPI_OP_READ) ? SPI_CMD_WIDTH + READ_WIDTH : SPI_CMD_WIDTH,
                    slave_frame_bits);
      end
    end
  end

  initial
  begin
    spi_cmd_t a;
    spi_cmd_t b;
    int f0;
    int r0;
    int n_reads;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    check_bit("reset cmd_rdy", 1'b1, cmd_rdy);
    check_bit("reset cs", 1'b1, cs);
    check_bit("reset sclk", 1'b0, sclk);
    check_bit("reset mosi", 1'b0, mosi);
    check_bit("reset read_vld", 1'b0, read_vld);
    finish_test("reset_state");

    f0 = slave_frames;
    r0 = read_pulses;
    a  = '{op: SPI_OP_WRITE, payload: 11'h5C3};
    send_cmd(a);
    wait_idle("write");
    check_count("write frames", 1, slave_frames - f0);
    check_count("write read_vld pulses", 0, read_pulses - r0);
    finish_test("write");

    f0 = slave_frames;
    r0 = read_pulses;
    a  = '{op: SPI_OP_READ, payload: 11'h2A7};
    send_cmd(a);
    wait_idle("read");
    check_count("read frames", 1, slave_frames - f0);
    check_count("read read_vld pulses", 1, read_pulses - r0);
    check_read("read data held", spi_ref_read(a), read_data);
    finish_test("read");

    f0 = slave_frames;
    a  = '{op: SPI_OP_READ, payload: 11'h13C};
    b  = '{op: SPI_OP_WRITE, payload: ~a.payload};
    send_cmd(a);
    check_bit("busy cmd_rdy", 1'b0, cmd_rdy);
    cmd_in  = b;  // Held while the first frame runs
    cmd_vld = 1'b1;
    wait_rdy("busy hold");
    check_count("busy frames before release", 1, slave_frames - f0);
    exp_cmd_q.push_back(b);
    @(negedge clk);
    cmd_vld = 1'b0;
    wait_idle("busy ignore");
    check_count("busy total frames", 2, slave_frames - f0);
    finish_test("busy_ignore");

    f0      = slave_frames;
    r0      = read_pulses;
    n_reads = 0;
    for (int i = 0; i < 20; i++)
    begin
      random_cmd(a);
      if (a.op == SPI_OP_READ)
        n_reads++;
      send_cmd(a);
    end
    wait_idle("random mix");
    check_count("mix frames", 20, slave_frames - f0);
    check_count("mix reads", n_reads, read_pulses - r0);
    finish_test("random_mix");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- all.f
source/spi_pkg.sv
source/spi_cmd_decode.sv
source/spi_shift_engine.sv
source/spi_read_capture.sv
source/spi_ctrl_top.sv
verif/spi_slave_model.sv
verif/spi_ctrl_tb.sv

//--- Bender.yml
package:
  name: spi_ctrl

sources:
  - source/spi_pkg.sv
  - source/spi_cmd_decode.sv
  - source/spi_shift_engine.sv
  - source/spi_read_capture.sv
  - source/spi_ctrl_top.sv
  - target: test
    files:
      - verif/spi_slave_model.sv
      - verif/spi_ctrl_tb.sv
